//--- lc4_pkg.sv
package lc4_pkg;

    // machine word for data, addresses and instructions
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // one-hot condition codes, bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0]  nzp_t;

    // stall code shown on the commit trace
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_t;

    // decoded control carried down the pipe
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctrl_t;

    localparam logic [3:0] OP_BR      = 4'b0000;
    localparam logic [3:0] OP_ARITH   = 4'b0001;
    localparam logic [3:0] OP_LOGIC   = 4'b0101;
    localparam logic [3:0] OP_LDR     = 4'b0110;
    localparam logic [3:0] OP_STR     = 4'b0111;
    localparam logic [3:0] OP_CONST   = 4'b1001;
    localparam logic [3:0] OP_HICONST = 4'b1101;

    localparam word_t PC_RESET = 16'h8200;
    localparam int    NUM_REGS = 8;

    // registers clear to zero, so the condition codes start at zero too
    localparam nzp_t NZP_RESET = 3'b010;

    // execute operand sources
    localparam logic [1:0] BYP_RF = 2'd0;
    localparam logic [1:0] BYP_M  = 2'd1;
    localparam logic [1:0] BYP_W  = 2'd2;

    // condition codes of a result word
    function automatic nzp_t nzp_of(input word_t value);
        nzp_t res;
        if (value == '0) begin
            res = 3'b010;
        end else if (value[15]) begin
            res = 3'b100;
        end else begin
            res = 3'b001;
        end
        return res;
    endfunction

endpackage

//--- lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    output lc4_pkg::ctrl_t o_ctrl
);
    import lc4_pkg::*;

    logic [3:0] opcode;
    reg_idx_t   f_hi;
    reg_idx_t   f_mid;
    reg_idx_t   f_lo;

    assign opcode = i_insn[15:12];
    assign f_hi   = i_insn[11:9];
    assign f_mid  = i_insn[8:6];
    assign f_lo   = i_insn[2:0];

    always_comb begin
        o_ctrl = '0;
        case (opcode)
            OP_BR: begin
                // an empty nzp mask is the NOP encoding
                o_ctrl.is_branch = |f_hi;
            end
            OP_ARITH: begin
                // ADD, SUB and ADD-immediate, the MUL/DIV sub-ops stay a NOP
                if (i_insn[5] || !i_insn[3]) begin
                    o_ctrl.rs     = f_mid;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt     = f_lo;
                    o_ctrl.rt_re  = !i_insn[5];
                    o_ctrl.rd     = f_hi;
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                o_ctrl.rs     = f_mid;
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.rt     = f_lo;
                // NOT and AND-immediate have no second source
                o_ctrl.rt_re  = !i_insn[5] && (i_insn[4:3] != 2'b01);
                o_ctrl.rd     = f_hi;
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_LDR: begin
                o_ctrl.rs      = f_mid;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd      = f_hi;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                // rt carries the store data
                o_ctrl.rs       = f_mid;
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt       = f_hi;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rd     = f_hi;
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_HICONST: begin
                // keeps the low byte of rd, so rd is also a source
                if (i_insn[8]) begin
                    o_ctrl.rs     = f_hi;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rd     = f_hi;
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs_data,
    input  lc4_pkg::word_t i_rt_data,
    output lc4_pkg::word_t o_result
);
    import lc4_pkg::*;

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t arith_res;
    word_t logic_res;
    word_t br_target;

    // sign-extended immediates
    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    assign br_target = i_pc + 16'd1 + imm9;

    always_comb begin
        if (i_insn[5]) begin
            arith_res = i_rs_data + imm5;
        end else if (i_insn[4]) begin
            arith_res = i_rs_data - i_rt_data;
        end else begin
            arith_res = i_rs_data + i_rt_data;
        end
    end

    always_comb begin
        if (i_insn[5]) begin
            logic_res = i_rs_data & imm5;
        end else begin
            case (i_insn[4:3])
                2'b00:   logic_res = i_rs_data & i_rt_data;
                2'b01:   logic_res = ~i_rs_data;
                2'b10:   logic_res = i_rs_data | i_rt_data;
                default: logic_res = i_rs_data ^ i_rt_data;
            endcase
        end
    end

    always_comb begin
        case (i_insn[15:12])
            OP_BR:          o_result = br_target;
            OP_ARITH:       o_result = arith_res;
            OP_LOGIC:       o_result = logic_res;
            OP_LDR, OP_STR: o_result = i_rs_data + imm6;
            OP_CONST:       o_result = imm9;
            // upper byte from the instruction, lower byte kept from rd
            OP_HICONST:     o_result = {i_insn[7:0], i_rs_data[7:0]};
            default:        o_result = '0;
        endcase
    end

endmodule

//--- lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::reg_idx_t i_rs,
    input  lc4_pkg::reg_idx_t i_rt,
    input  lc4_pkg::reg_idx_t i_rd,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

//--- lc4_hazard_unit.sv
`timescale 1ns/1ps

module lc4_hazard_unit (
    input  lc4_pkg::ctrl_t i_d_ctrl,
    input  lc4_pkg::ctrl_t i_x_ctrl,
    input  lc4_pkg::ctrl_t i_m_ctrl,
    input  lc4_pkg::ctrl_t i_w_ctrl,
    output logic           o_stall,
    output logic [1:0]     o_rs_sel,
    output logic [1:0]     o_rt_sel,
    output logic           o_store_sel
);
    import lc4_pkg::*;

    logic load_use;
    logic load_branch;
    logic rs_dep;
    logic rt_dep;

    // newest producer wins, memory stage before writeback
    function automatic logic [1:0] bypass_sel(
        input reg_idx_t src,
        input logic     re,
        input ctrl_t    m_ctrl,
        input ctrl_t    w_ctrl
    );
        logic [1:0] sel;
        sel = BYP_RF;
        if (re && m_ctrl.rf_we && (m_ctrl.rd == src)) begin
            sel = BYP_M;
        end else if (re && w_ctrl.rf_we && (w_ctrl.rd == src)) begin
            sel = BYP_W;
        end
        return sel;
    endfunction

    // decode reads the register a load in execute is about to fill
    assign rs_dep = i_d_ctrl.rs_re && (i_d_ctrl.rs == i_x_ctrl.rd);

    // store data is fixed up later by the WM bypass
    assign rt_dep = i_d_ctrl.rt_re && !i_d_ctrl.is_store && (i_d_ctrl.rt == i_x_ctrl.rd);

    assign load_use = i_x_ctrl.is_load && i_x_ctrl.rf_we && (rs_dep || rt_dep);

    // the branch needs the load's condition codes, only ready one cycle later
    assign load_branch = i_d_ctrl.is_branch && i_x_ctrl.is_load;

    assign o_stall = load_use || load_branch;

    assign o_rs_sel = bypass_sel(i_x_ctrl.rs, i_x_ctrl.rs_re, i_m_ctrl, i_w_ctrl);
    assign o_rt_sel = bypass_sel(i_x_ctrl.rt, i_x_ctrl.rt_re, i_m_ctrl, i_w_ctrl);

    // writeback holds the instruction just older than the store
    assign o_store_sel = i_m_ctrl.is_store && i_w_ctrl.rf_we &&
                         (i_m_ctrl.rt == i_w_ctrl.rd);

endmodule

//--- lc4_pipeline.sv
`timescale 1ns/1ps

module lc4_pipeline (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::word_t    i_cur_insn,
    input  lc4_pkg::word_t    i_cur_dmem_data,
    output lc4_pkg::word_t    o_cur_pc,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_towrite,
    output lc4_pkg::stall_t   o_commit_stall,
    output lc4_pkg::word_t    o_commit_pc,
    output lc4_pkg::word_t    o_commit_insn,
    output logic              o_commit_rf_we,
    output lc4_pkg::reg_idx_t o_commit_rf_wsel,
    output lc4_pkg::word_t    o_commit_rf_data,
    output lc4_pkg::nzp_t     o_commit_nzp
);
    import lc4_pkg::*;

    word_t      pc_q;
    word_t      pc_next;
    nzp_t       nzp_q;
    logic       stall;
    logic [1:0] rs_sel;
    logic [1:0] rt_sel;
    logic       store_sel;

    word_t      d_insn;
    word_t      d_pc;
    stall_t     d_stall;
    ctrl_t      d_ctrl;
    word_t      rf_rs_data;
    word_t      rf_rt_data;

    word_t      x_insn;
    word_t      x_pc;
    stall_t     x_stall;
    ctrl_t      x_ctrl;
    word_t      x_rs_data;
    word_t      x_rt_data;
    word_t      x_rs_byp;
    word_t      x_rt_byp;
    word_t      x_result;
    nzp_t       x_nzp;
    logic       x_taken;

    word_t      m_insn;
    word_t      m_pc;
    stall_t     m_stall;
    ctrl_t      m_ctrl;
    word_t      m_result;
    word_t      m_rt_data;
    nzp_t       m_nzp;
    nzp_t       m_load_nzp;

    word_t      w_insn;
    word_t      w_pc;
    stall_t     w_stall;
    ctrl_t      w_ctrl;
    word_t      w_result;
    word_t      w_dmem_data;
    word_t      w_wdata;
    nzp_t       w_nzp;

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .i_rd      (w_ctrl.rd),
        .i_wdata   (w_wdata),
        .i_we      (w_ctrl.rf_we),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl    (d_ctrl),
        .i_x_ctrl    (x_ctrl),
        .i_m_ctrl    (m_ctrl),
        .i_w_ctrl    (w_ctrl),
        .o_stall     (stall),
        .o_rs_sel    (rs_sel),
        .o_rt_sel    (rt_sel),
        .o_store_sel (store_sel)
    );

    lc4_alu u_alu (
        .i_insn    (x_insn),
        .i_pc      (x_pc),
        .i_rs_data (x_rs_byp),
        .i_rt_data (x_rt_byp),
        .o_result  (x_result)
    );

    // MX and WX bypass
    assign x_rs_byp = (rs_sel == BYP_M) ? m_result :
                      (rs_sel == BYP_W) ? w_wdata : x_rs_data;
    assign x_rt_byp = (rt_sel == BYP_M) ? m_result :
                      (rt_sel == BYP_W) ? w_wdata : x_rt_data;

    assign x_nzp   = nzp_of(x_result);
    assign x_taken = x_ctrl.is_branch && |(x_insn[11:9] & nzp_q);
    assign pc_next = x_taken ? x_result : (stall ? pc_q : pc_q + 16'd1);

    assign m_load_nzp = nzp_of(i_cur_dmem_data);
    assign w_wdata    = w_ctrl.is_load ? w_dmem_data : w_result;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q    <= PC_RESET;
            d_insn  <= '0;
            d_stall <= STALL_BRANCH;
            x_ctrl  <= '0;
            x_stall <= STALL_BRANCH;
            m_ctrl  <= '0;
            m_stall <= STALL_BRANCH;
            w_ctrl  <= '0;
            w_stall <= STALL_BRANCH;
            nzp_q   <= NZP_RESET;
        end else begin
            pc_q <= pc_next;
            // a taken branch squashes fetch and decode
            if (x_taken) begin
                d_insn  <= '0;
                d_stall <= STALL_BRANCH;
                x_ctrl  <= '0;
                x_stall <= STALL_BRANCH;
            end else if (stall) begin
                x_ctrl  <= '0;
                x_stall <= STALL_LOAD;
            end else begin
                d_insn  <= i_cur_insn;
                d_stall <= STALL_NONE;
                x_ctrl  <= d_ctrl;
                x_stall <= d_stall;
            end
            m_ctrl  <= x_ctrl;
            m_stall <= x_stall;
            w_ctrl  <= m_ctrl;
            w_stall <= m_stall;
            // younger instruction leaving execute overrides an older load
            if (x_ctrl.nzp_we && !x_ctrl.is_load) begin
                nzp_q <= x_nzp;
            end else if (m_ctrl.is_load) begin
                nzp_q <= m_load_nzp;
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_pc <= pc_q;
        end
        x_insn      <= d_insn;
        x_pc        <= d_pc;
        x_rs_data   <= rf_rs_data;
        x_rt_data   <= rf_rt_data;
        m_insn      <= x_insn;
        m_pc        <= x_pc;
        m_result    <= x_result;
        m_rt_data   <= x_rt_byp;
        m_nzp       <= x_ctrl.nzp_we ? x_nzp : 3'b000;
        w_insn      <= m_insn;
        w_pc        <= m_pc;
        w_result    <= m_result;
        w_dmem_data <= i_cur_dmem_data;
        w_nzp       <= m_ctrl.is_load ? m_load_nzp : m_nzp;
    end

    assign o_cur_pc       = pc_q;
    assign o_dmem_addr    = (m_ctrl.is_load || m_ctrl.is_store) ? m_result : '0;
    assign o_dmem_we      = m_ctrl.is_store;
    // WM bypass for store data
    assign o_dmem_towrite = !m_ctrl.is_store ? '0 : (store_sel ? w_wdata : m_rt_data);

    assign o_commit_stall   = w_stall;
    assign o_commit_pc      = w_pc;
    assign o_commit_insn    = w_insn;
    assign o_commit_rf_we   = w_ctrl.rf_we;
    assign o_commit_rf_wsel = w_ctrl.rd;
    assign o_commit_rf_data = w_wdata;
    assign o_commit_nzp     = w_nzp;

endmodule

//--- tb_lc4_model.svh
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

// architectural state, one step per retired instruction
word_t      arch_pc;
word_t      arch_regs [8];
logic [2:0] arch_nzp;
word_t      arch_dmem [DMEM_DEPTH];

// what the next retirement must show
word_t      exp_pc;
word_t      exp_insn;
logic       exp_we;
logic [2:0] exp_wsel;
word_t      exp_data;
logic [2:0] exp_nzp;
logic       exp_store;
word_t      exp_st_addr;
word_t      exp_st_data;

task automatic reset_model();
    arch_pc  = 16'h8200;
    // all registers are zero, so the last result counts as zero
    arch_nzp = 3'b010;
    for (int k = 0; k < 8; k++) begin
        arch_regs[k[2:0]] = 16'h0000;
    end
endtask

task automatic step_model();
    word_t      insn;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      next_pc;
    logic [2:0] d;
    insn      = imem[arch_pc[7:0]];
    d         = insn[11:9];
    a         = arch_regs[insn[8:6]];
    b         = arch_regs[insn[2:0]];
    res       = 16'h0000;
    addr      = a + {{10{insn[5]}}, insn[5:0]};
    next_pc   = arch_pc + 16'd1;
    exp_pc    = arch_pc;
    exp_insn  = insn;
    exp_we    = 1'b1;
    exp_store = 1'b0;
    case (insn[15:12])
        OP_ARITH: begin
            case (insn[5:3])
                3'b000:  res = a + b;
                3'b010:  res = a - b;
                default: res = a + {{11{insn[4]}}, insn[4:0]};
            endcase
        end
        OP_LOGIC: begin
            case (insn[5:3])
                3'b000:  res = a & b;
                3'b001:  res = ~a;
                3'b010:  res = a | b;
                3'b011:  res = a ^ b;
                default: res = a & {{11{insn[4]}}, insn[4:0]};
            endcase
        end
        OP_LDR:     res = arch_dmem[addr[7:0]];
        OP_STR: begin
            exp_we               = 1'b0;
            exp_store            = 1'b1;
            exp_st_addr          = addr;
            exp_st_data          = arch_regs[d];
            arch_dmem[addr[7:0]] = arch_regs[d];
        end
        OP_CONST:   res = {{7{insn[8]}}, insn[8:0]};
        OP_HICONST: res = {insn[7:0], arch_regs[d][7:0]};
        default: begin
            // BR, with the empty mask acting as NOP
            exp_we = 1'b0;
            if ((insn[11:9] & arch_nzp) != 3'b000) begin
                next_pc = next_pc + {{7{insn[8]}}, insn[8:0]};
            end
        end
    endcase
    if (exp_we) begin
        arch_regs[d] = res;
        arch_nzp     = res[15] ? 3'b100 : ((res == 16'h0000) ? 3'b010 : 3'b001);
    end
    exp_wsel = d;
    exp_data = res;
    exp_nzp  = arch_nzp;
    arch_pc  = next_pc;
endtask

`endif

//--- tb_lc4.sv
`timescale 1ns/1ps

module tb_lc4;
    import lc4_pkg::*;

    localparam int SEED          = 38203;
    localparam int IMEM_DEPTH    = 256;
    localparam int DMEM_DEPTH    = 256;
    localparam int PROG_LEN      = IMEM_DEPTH;
    localparam int COMMIT_TARGET = 400;
    localparam int CYCLE_LIMIT   = COMMIT_TARGET * 4 + 200;
    localparam int RESET_CYCLES  = 16;

    logic     gwe;
    logic     i_rst;
    word_t    i_cur_insn;
    word_t    i_cur_dmem_data;
    word_t    o_cur_pc;
    word_t    o_dmem_addr;
    logic     o_dmem_we;
    word_t    o_dmem_towrite;
    stall_t   o_commit_stall;
    word_t    o_commit_pc;
    word_t    o_commit_insn;
    logic     o_commit_rf_we;
    reg_idx_t o_commit_rf_wsel;
    word_t    o_commit_rf_data;
    nzp_t     o_commit_nzp;

    word_t       imem [IMEM_DEPTH];
    word_t       dmem [DMEM_DEPTH];
    // stores seen in memory stage until they retire
    logic [31:0] store_q [$];
    integer      seed;
    int          cycles;
    int          commits;
    int          value_errors;
    int          other_errors;

    `include "tb_lc4_model.svh"

    lc4_pipeline dut_i (
        .gwe              (gwe),
        .i_rst            (i_rst),
        .i_cur_insn       (i_cur_insn),
        .i_cur_dmem_data  (i_cur_dmem_data),
        .o_cur_pc         (o_cur_pc),
        .o_dmem_addr      (o_dmem_addr),
        .o_dmem_we        (o_dmem_we),
        .o_dmem_towrite   (o_dmem_towrite),
        .o_commit_stall   (o_commit_stall),
        .o_commit_pc      (o_commit_pc),
        .o_commit_insn    (o_commit_insn),
        .o_commit_rf_we   (o_commit_rf_we),
        .o_commit_rf_wsel (o_commit_rf_wsel),
        .o_commit_rf_data (o_commit_rf_data),
        .o_commit_nzp     (o_commit_nzp)
    );

    always #4 gwe = ~gwe;

    // both memories answer in the same cycle
    assign i_cur_insn      = imem[o_cur_pc[7:0]];
    assign i_cur_dmem_data = dmem[o_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
        end
    end

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
            value_errors++;
        end
    endtask

    // random program where most loads and stores use a base just set by CONST
    task automatic build_program();
        logic [31:0] r;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic        prev_load;
        logic [2:0]  ld_rd;
        logic [2:0]  ld_base;
        int          i;
        i         = 0;
        prev_load = 1'b0;
        ld_rd     = 3'd0;
        ld_base   = 3'd0;
        while (i < PROG_LEN) begin
            r  = $random(seed);
            rd = r[6:4];
            rs = r[9:7];
            rt = r[12:10];
            case (r[3:0])
                // forward branches only
                // an empty mask encodes a NOP
                4'd0, 4'd1: imem[i[7:0]] = {OP_BR, r[15:13], 6'd0, r[18:16]};
                4'd2, 4'd3: imem[i[7:0]] = {OP_ARITH, rd, rs, 1'b0, r[13], 1'b0, rt};
                4'd4:       imem[i[7:0]] = {OP_ARITH, rd, rs, 1'b1, r[17:13]};
                4'd5, 4'd6: imem[i[7:0]] = {OP_LOGIC, rd, rs, 1'b0, r[14:13], rt};
                4'd7:       imem[i[7:0]] = {OP_LOGIC, rd, rs, 1'b1, r[17:13]};
                4'd8, 4'd9: imem[i[7:0]] = {OP_CONST, rd, r[21:13]};
                4'd10:      imem[i[7:0]] = {OP_HICONST, rd, 1'b1, r[20:13]};
                default: begin
                    if (r[3:0] >= 4'd14 && prev_load) begin
                        // store of the register just loaded
                        imem[i[7:0]] = {OP_STR, ld_rd, ld_base, r[18:13]};
                    end else if (i + 1 < PROG_LEN) begin
                        imem[i[7:0]] = {OP_CONST, rs, r[21:13]};
                        i++;
                        imem[i[7:0]] = {((r[3:0] >= 4'd14) ? OP_STR : OP_LDR), rd, rs, r[27:22]};
                    end else begin
                        imem[i[7:0]] = {OP_CONST, rd, r[21:13]};
                    end
                end
            endcase
            prev_load = (imem[i[7:0]][15:12] == OP_LDR);
            ld_rd     = rd;
            ld_base   = rs;
            i++;
        end
    endtask

    task automatic fill_data();
        logic [31:0] r;
        for (int j = 0; j < DMEM_DEPTH; j++) begin
            r = $random(seed);
            dmem[j[7:0]] <= r[15:0];
            arch_dmem[j[7:0]] = r[15:0];
        end
    endtask

    task automatic verify_reset_state();
        compare_word("o_cur_pc", 16'h8200, o_cur_pc);
        compare_word("o_dmem_we", 16'h0000, {15'd0, o_dmem_we});
        compare_word("o_commit_rf_we", 16'h0000, {15'd0, o_commit_rf_we});
        compare_word("o_commit_stall", 16'h0002, {14'd0, o_commit_stall});
    endtask

    task automatic sample_cycle();
        logic [31:0] seen;
        if (o_dmem_we) begin
            store_q.push_back({o_dmem_addr, o_dmem_towrite});
        end
        if (o_commit_stall == STALL_NONE) begin
            assert (cycles >= 4) else begin
                $display("an instruction retired %0d cycles after reset, too early", cycles);
                other_errors++;
            end
            step_model();
            compare_word("o_commit_pc", exp_pc, o_commit_pc);
            compare_word("o_commit_insn", exp_insn, o_commit_insn);
            compare_word("o_commit_rf_we", {15'd0, exp_we}, {15'd0, o_commit_rf_we});
            if (exp_we) begin
                compare_word("o_commit_rf_wsel", {13'd0, exp_wsel}, {13'd0, o_commit_rf_wsel});
                compare_word("o_commit_rf_data", exp_data, o_commit_rf_data);
                compare_word("o_commit_nzp", {13'd0, exp_nzp}, {13'd0, o_commit_nzp});
            end
            if (exp_store) begin
                assert (store_q.size() > 0) else begin
                    $display("a store retired without writing data memory");
                    other_errors++;
                end
                if (store_q.size() > 0) begin
                    seen = store_q.pop_front();
                    compare_word("o_dmem_addr", exp_st_addr, seen[31:16]);
                    compare_word("o_dmem_towrite", exp_st_data, seen[15:0]);
                end
            end
            commits++;
        end
    endtask

    initial begin
        gwe          = 1'b0;
        i_rst        = 1'b1;
        seed         = SEED;
        cycles       = 0;
        commits      = 0;
        value_errors = 0;
        other_errors = 0;
        build_program();
        fill_data();
        reset_model();
        repeat (RESET_CYCLES) @(negedge gwe);
        verify_reset_state();
        i_rst = 1'b0;
        while (commits < COMMIT_TARGET && cycles < CYCLE_LIMIT) begin
            @(negedge gwe);
            cycles++;
            sample_cycle();
        end
        assert (commits >= COMMIT_TARGET) else begin
            $display("timeout: commit target not reached");
            other_errors++;
        end
        $display("errors: %0d value, %0d other (%0d commits in %0d cycles)",
                 value_errors, other_errors, commits, cycles);
        if (value_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_pipeline.sv
tb_lc4.sv

//--- run.sh
#!/bin/sh
# builds and runs the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_lc4 -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lc4 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1
